/* design/beat_pkg.sv */
package beat_pkg;

    //////////////////////////////////////////////////
    // Basic types

    typedef logic [11:0] coord_t;
    typedef logic [13:0] depth_t;
    typedef logic [17:0] game_time_t;

    typedef enum logic [1:0] {
        DIR_UP,
        DIR_DOWN,
        DIR_LEFT,
        DIR_RIGHT
    } dir_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PLAYING,
        ST_WON,
        ST_LOST
    } game_state_e;

    // Saber tip from the tracker
    typedef struct packed {
        coord_t x;
        coord_t y;
        depth_t z;
    } hand_pos_t;

    typedef struct packed {
        coord_t     x;
        coord_t     y;
        game_time_t arrive;
        logic       color;
        dir_e       dir;
        logic [7:0] id;
    } chart_entry_t;

    typedef struct packed {
        logic         valid;
        chart_entry_t entry;
        depth_t       depth;
    } slot_t;

    typedef struct packed {
        logic       sliced;
        logic       missed;
        logic [7:0] id;
    } game_event_t;

    typedef struct packed {
        game_state_e state;
        logic [11:0] score;
        logic [3:0]  health;
        logic [2:0]  combo;
        game_time_t  game_time;
    } game_status_t;

    //////////////////////////////////////////////////
    // Chart and scoring

    localparam int CHART_LEN = 6;

    // Arrivals four ticks apart, so at most three blocks on screen
    localparam chart_entry_t CHART [CHART_LEN] = '{
        '{12'd120, 12'd200, 18'd10, 1'b0, DIR_DOWN,  8'd1},
        '{12'd320, 12'd160, 18'd14, 1'b1, DIR_RIGHT, 8'd2},
        '{12'd200, 12'd260, 18'd18, 1'b0, DIR_UP,    8'd3},
        '{12'd400, 12'd220, 18'd22, 1'b1, DIR_LEFT,  8'd4},
        '{12'd160, 12'd120, 18'd26, 1'b0, DIR_DOWN,  8'd5},
        '{12'd360, 12'd300, 18'd30, 1'b1, DIR_RIGHT, 8'd6}
    };

    localparam int POINTS_PER_HIT = 10;
    localparam int COMBO_MAX      = 7;
    localparam int MULT_CAP       = 4;
    localparam int HEALTH_MAX     = 3;

endpackage

/* design/hand_sample_port.sv */
`timescale 1ns/1ns

module hand_sample_port (
    input  logic                clk_in,
    input  logic                rst_in,
    input  logic                hand_req,
    input  beat_pkg::hand_pos_t hand,
    output logic                hand_ack,
    input  logic                ready,
    output logic                swing_valid,
    output beat_pkg::hand_pos_t curr,
    output beat_pkg::hand_pos_t prev
);

    typedef enum logic {
        HS_WAIT,
        HS_ACK
    } hs_state_e;

    hs_state_e state;
    logic      primed;
    logic      capture;

    // Accept only while the detector is idle
    assign capture  = (state == HS_WAIT) && hand_req && ready;
    assign hand_ack = (state == HS_ACK);

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state       <= HS_WAIT;
            primed      <= 1'b0;
            swing_valid <= 1'b0;
        end else begin
            swing_valid <= capture;
            case (state)
                HS_WAIT: if (capture) begin
                    state  <= HS_ACK;
                    primed <= 1'b1;
                end
                HS_ACK: if (!hand_req) begin
                    state <= HS_WAIT;
                end
                default: state <= HS_WAIT;
            endcase
        end
    end

    // Saber history, first sample has no swing
    always_ff @(posedge clk_in) begin
        if (capture) begin
            curr <= hand;
            prev <= primed ? curr : hand;
        end
    end

endmodule

/* design/game_state.sv */
`timescale 1ns/1ns

module game_state #(
    parameter int TICK_DIV = 16
) (
    input  logic                   clk_in,
    input  logic                   rst_in,
    input  logic                   start,
    input  beat_pkg::game_event_t  evt,
    output logic                   tick,
    output beat_pkg::game_status_t status
);
    import beat_pkg::*;

    localparam int DIV_W = $clog2(TICK_DIV);

    // Game is won one tick after the last block arrives
    localparam game_time_t WIN_TIME = CHART[CHART_LEN-1].arrive + 18'd1;

    logic [DIV_W-1:0] div_cnt;
    logic [3:0]       mult;
    logic [11:0]      gain;

    // Multiplier uses the combo before the hit
    always_comb begin
        if ({1'b0, status.combo} + 4'd1 < 4'(MULT_CAP)) begin
            mult = {1'b0, status.combo} + 4'd1;
        end else begin
            mult = 4'(MULT_CAP);
        end
        gain = 12'(POINTS_PER_HIT) * {8'd0, mult};
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            status.state     <= ST_IDLE;
            status.score     <= '0;
            status.health    <= 4'(HEALTH_MAX);
            status.combo     <= '0;
            status.game_time <= '0;
            div_cnt          <= '0;
            tick             <= 1'b0;
        end else begin
            tick <= 1'b0;
            case (status.state)
                ST_IDLE: if (start) begin
                    status.state     <= ST_PLAYING;
                    status.game_time <= '0;
                    div_cnt          <= '0;
                end
                ST_PLAYING: begin
                    // Tick divider and game clock
                    if (div_cnt == DIV_W'(TICK_DIV - 1)) begin
                        div_cnt          <= '0;
                        tick             <= 1'b1;
                        status.game_time <= status.game_time + 18'd1;
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end

                    if (status.game_time >= WIN_TIME && status.health != '0) begin
                        status.state <= ST_WON;
                    end

                    // Miss takes priority, a loss overrides a win
                    if (evt.missed) begin
                        status.combo  <= '0;
                        status.health <= status.health - 4'd1;
                        if (status.health <= 4'd1) begin
                            status.state <= ST_LOST;
                        end
                    end else if (evt.sliced) begin
                        status.score <= status.score + gain;
                        if (status.combo != 3'(COMBO_MAX)) begin
                            status.combo <= status.combo + 3'd1;
                        end
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

/* design/block_positions.sv */
`timescale 1ns/1ns

module block_positions #(
    parameter int APPROACH  = 8,
    parameter int NUM_SLOTS = 4
) (
    input  logic                                   clk_in,
    input  logic                                   rst_in,
    input  logic                                   tick,
    input  beat_pkg::game_status_t                 status,
    input  logic                                   cut,
    input  logic [$clog2(NUM_SLOTS)-1:0]           cut_slot,
    output beat_pkg::slot_t [NUM_SLOTS-1:0]        slots,
    output logic                                   missed,
    output logic [7:0]                             missed_id
);
    import beat_pkg::*;

    localparam int IDX_W = $clog2(NUM_SLOTS);
    localparam int PTR_W = $clog2(CHART_LEN + 1);

    logic [PTR_W-1:0] ptr;
    logic             load_due;
    logic             free_found;
    logic [IDX_W-1:0] free_idx;
    logic             cut_ok;
    depth_t           new_depth [NUM_SLOTS];

    // A miss in the same cycle cancels the cut
    assign cut_ok = cut && !missed;

    assign load_due = (ptr < PTR_W'(CHART_LEN)) &&
                      (CHART[ptr].arrive == status.game_time + game_time_t'(APPROACH));

    // Lowest free slot
    always_comb begin
        free_found = 1'b0;
        free_idx   = '0;
        for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
            if (!slots[i].valid) begin
                free_found = 1'b1;
                free_idx   = IDX_W'(i);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_SLOTS; i++) begin
            new_depth[i] = depth_t'(slots[i].entry.arrive - status.game_time);
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                slots[i].valid <= 1'b0;
            end
            ptr    <= '0;
            missed <= 1'b0;
        end else begin
            missed <= 1'b0;
            if (tick) begin
                // Approach and retire
                for (int i = 0; i < NUM_SLOTS; i++) begin
                    if (slots[i].valid) begin
                        slots[i].depth <= new_depth[i];
                        if (new_depth[i] == '0 && !(cut_ok && cut_slot == IDX_W'(i))) begin
                            slots[i].valid <= 1'b0;
                            missed         <= 1'b1;
                            missed_id      <= slots[i].entry.id;
                        end
                    end
                end
                // Next chart entry enters the track
                if (load_due) begin
                    ptr <= ptr + 1'b1;
                    if (free_found) begin
                        slots[free_idx] <= '{valid: 1'b1, entry: CHART[ptr],
                                             depth: depth_t'(APPROACH)};
                    end
                end
            end
            if (cut_ok) begin
                slots[cut_slot].valid <= 1'b0;
            end
        end
    end

endmodule

/* design/slice_detector.sv */
`timescale 1ns/1ns

module slice_detector #(
    parameter int NUM_SLOTS  = 4,
    parameter int HIT_RADIUS = 24,
    parameter int HIT_DEPTH  = 3,
    parameter int MIN_SWING  = 8
) (
    input  logic                            clk_in,
    input  logic                            rst_in,
    input  logic                            swing_valid,
    input  beat_pkg::hand_pos_t             curr,
    input  beat_pkg::hand_pos_t             prev,
    input  beat_pkg::slot_t [NUM_SLOTS-1:0] slots,
    output logic                            ready,
    output logic                            cut,
    output logic [$clog2(NUM_SLOTS)-1:0]    cut_slot,
    output logic [7:0]                      cut_id
);
    import beat_pkg::*;

    localparam int IDX_W = $clog2(NUM_SLOTS);

    logic             busy;
    logic [IDX_W-1:0] idx;
    dir_e             swing_dir;
    dir_e             dir_now;
    coord_t           dx_mag, dy_mag, swing_mag;
    logic             swing_ok;
    slot_t            s;
    coord_t           ex, ey;
    logic             hit;

    //////////////////////////////////////////////////
    // Swing direction, dominant axis wins

    always_comb begin
        dx_mag = (curr.x > prev.x) ? curr.x - prev.x : prev.x - curr.x;
        dy_mag = (curr.y > prev.y) ? curr.y - prev.y : prev.y - curr.y;
        if (dx_mag >= dy_mag) begin
            swing_mag = dx_mag;
            dir_now   = (curr.x > prev.x) ? DIR_RIGHT : DIR_LEFT;
        end else begin
            swing_mag = dy_mag;
            dir_now   = (curr.y > prev.y) ? DIR_DOWN : DIR_UP;
        end
        swing_ok = swing_mag >= coord_t'(MIN_SWING);
    end

    // Hit test on the slot under scan
    always_comb begin
        s   = slots[idx];
        ex  = (curr.x > s.entry.x) ? curr.x - s.entry.x : s.entry.x - curr.x;
        ey  = (curr.y > s.entry.y) ? curr.y - s.entry.y : s.entry.y - curr.y;
        hit = s.valid && (s.depth != '0) && (s.depth <= depth_t'(HIT_DEPTH)) &&
              (ex <= coord_t'(HIT_RADIUS)) && (ey <= coord_t'(HIT_RADIUS)) &&
              (s.entry.dir == swing_dir);
    end

    assign ready = !busy;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            busy <= 1'b0;
            idx  <= '0;
            cut  <= 1'b0;
        end else begin
            cut <= 1'b0;
            if (!busy) begin
                if (swing_valid && swing_ok) begin
                    busy      <= 1'b1;
                    idx       <= '0;
                    swing_dir <= dir_now;
                end
            end else if (hit) begin
                // First match ends the scan
                cut      <= 1'b1;
                cut_slot <= idx;
                cut_id   <= s.entry.id;
                busy     <= 1'b0;
            end else if (idx == IDX_W'(NUM_SLOTS - 1)) begin
                busy <= 1'b0;
            end else begin
                idx <= idx + 1'b1;
            end
        end
    end

endmodule

/* design/beat_top.sv */
`timescale 1ns/1ns

module beat_top #(
    parameter int TICK_DIV   = 16,
    parameter int APPROACH   = 8,
    parameter int NUM_SLOTS  = 4,
    parameter int HIT_RADIUS = 24,
    parameter int HIT_DEPTH  = 3,
    parameter int MIN_SWING  = 8
) (
    input  logic                   clk_in,
    input  logic                   rst_in,
    input  logic                   start,
    input  logic                   hand_req,
    input  beat_pkg::hand_pos_t    hand,
    output logic                   hand_ack,
    output beat_pkg::game_event_t  event_out,
    output beat_pkg::game_status_t status
);
    import beat_pkg::*;

    localparam int IDX_W = $clog2(NUM_SLOTS);

    logic                    tick;
    slot_t [NUM_SLOTS-1:0]   slots;
    logic                    swing_valid;
    hand_pos_t               curr, prev;
    logic                    ready;
    logic                    cut;
    logic [IDX_W-1:0]        cut_slot;
    logic [7:0]              cut_id;
    logic                    missed;
    logic [7:0]              missed_id;

    hand_sample_port i_hand_port (
        .clk_in, .rst_in, .hand_req, .hand, .hand_ack,
        .ready, .swing_valid, .curr, .prev
    );

    game_state #(.TICK_DIV(TICK_DIV)) i_game_state (
        .clk_in, .rst_in, .start, .evt(event_out), .tick, .status
    );

    block_positions #(.APPROACH(APPROACH), .NUM_SLOTS(NUM_SLOTS)) i_blocks (
        .clk_in, .rst_in, .tick, .status, .cut, .cut_slot,
        .slots, .missed, .missed_id
    );

    slice_detector #(
        .NUM_SLOTS(NUM_SLOTS), .HIT_RADIUS(HIT_RADIUS),
        .HIT_DEPTH(HIT_DEPTH), .MIN_SWING(MIN_SWING)
    ) i_slicer (
        .clk_in, .rst_in, .swing_valid, .curr, .prev, .slots,
        .ready, .cut, .cut_slot, .cut_id
    );

    // Miss wins over a cut in the same cycle
    always_comb begin
        event_out = '0;
        if (missed) begin
            event_out.missed = 1'b1;
            event_out.id     = missed_id;
        end else if (cut) begin
            event_out.sliced = 1'b1;
            event_out.id     = cut_id;
        end
    end

endmodule

/* testbench/beat_assertions.sv */
`timescale 1ns/1ns

module beat_assertions (
    input logic                  clk_in,
    input logic                  rst_in,
    input logic                  hand_req,
    input logic                  hand_ack,
    input beat_pkg::game_event_t evt
);

    int failures = 0;

    //////////////////////////////////////////////////
    // Four-phase handshake

    ack_rise_needs_req: assert property (@(posedge clk_in) disable iff (rst_in)
        $rose(hand_ack) |-> $past(hand_req))
        else begin
            $error("hand_ack rose without a pending hand_req");
            failures++;
        end

    // Ack is held until the tracker lets go of req
    ack_fall_after_req: assert property (@(posedge clk_in) disable iff (rst_in)
        $fell(hand_ack) |-> !$past(hand_req))
        else begin
            $error("hand_ack fell while hand_req was still high");
            failures++;
        end

    //////////////////////////////////////////////////
    // Game events

    event_exclusive: assert property (@(posedge clk_in) disable iff (rst_in)
        !(evt.sliced && evt.missed))
        else begin
            $error("sliced and missed reported in the same cycle");
            failures++;
        end

endmodule

bind hand_sample_port beat_assertions i_hand_checks (
    .clk_in, .rst_in, .hand_req, .hand_ack, .evt('0)
);

bind game_state beat_assertions i_event_checks (
    .clk_in, .rst_in, .hand_req(1'b0), .hand_ack(1'b0), .evt
);

/* testbench/beat_tb.sv */
`timescale 1ns/1ns

module beat_tb;
    import beat_pkg::*;

    localparam int TICK_DIV        = 4;
    localparam int SWING           = 60;
    localparam int OFFSET_MAX      = 16;
    localparam int LAST_TICK       = int'(CHART[CHART_LEN-1].arrive) + 1;
    localparam int EVENT_WAIT      = 16 * TICK_DIV;
    localparam int WATCHDOG_CYCLES = LAST_TICK * TICK_DIV * 4;

    logic         clk_in;
    logic         rst_in;
    logic         start;
    logic         hand_req;
    hand_pos_t    hand;
    logic         hand_ack;
    game_event_t  event_out;
    game_status_t status;

    int errors;
    int exp_score;
    int exp_combo;
    int exp_health;

    beat_top #(.TICK_DIV(TICK_DIV)) i_dut (
        .clk_in, .rst_in, .start, .hand_req, .hand, .hand_ack, .event_out, .status
    );

    initial begin
        clk_in = 1'b0;
        forever #4 clk_in = ~clk_in;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_in);
        $display("Run stopped by the watchdog after %0d cycles", WATCHDOG_CYCLES);
        $display("Checks failed");
        $finish;
    end

    //////////////////////////////////////////////////
    // Helpers and compare tasks

    task automatic step();
        @(posedge clk_in);
        #1;
    endtask

    function automatic game_status_t pack_status(game_state_e st, int score, int health,
                                                 int combo, int t);
        return '{state: st, score: 12'(score), health: 4'(health),
                 combo: 3'(combo), game_time: game_time_t'(t)};
    endfunction

    function automatic game_event_t pack_event(logic sliced, logic missed, logic [7:0] id);
        return '{sliced: sliced, missed: missed, id: id};
    endfunction

    function automatic string status_text(game_status_t s);
        return $sformatf("%s score %0d health %0d combo %0d time %0d", s.state.name(),
                         s.score, s.health, s.combo, s.game_time);
    endfunction

    function automatic string event_text(game_event_t e);
        return $sformatf("sliced %b missed %b id %0d", e.sliced, e.missed, e.id);
    endfunction

    task automatic check_status(input string name, input game_status_t exp_s,
                                input game_status_t act_s);
        if (act_s !== exp_s) begin
            errors++;
            $display("** Error %s: expected %s, actual %s", name, status_text(exp_s),
                     status_text(act_s));
        end
    endtask

    task automatic check_event(input string name, input game_event_t exp_e,
                               input game_event_t act_e);
        if (act_e !== exp_e) begin
            errors++;
            $display("** Error %s: expected %s, actual %s", name, event_text(exp_e),
                     event_text(act_e));
        end
    endtask

    task automatic reset_dut();
        rst_in   = 1'b1;
        start    = 1'b0;
        hand_req = 1'b0;
        repeat (2) step();
        rst_in     = 1'b0;
        exp_score  = 0;
        exp_combo  = 0;
        exp_health = HEALTH_MAX;
    endtask

    task automatic wait_time(input string name, input int t);
        int n;
        n = 0;
        while (status.game_time != game_time_t'(t) && n < LAST_TICK * TICK_DIV) begin
            step();
            n++;
        end
        if (status.game_time != game_time_t'(t)) begin
            errors++;
            $display("%s: game time never reached %0d", name, t);
        end
    endtask

    // Returns one cycle after the pulse, when the status has caught up
    task automatic wait_event(input string name, input game_event_t exp_e);
        int n;
        n = 0;
        while (!(event_out.sliced || event_out.missed) && n < EVENT_WAIT) begin
            step();
            n++;
        end
        if (!(event_out.sliced || event_out.missed)) begin
            errors++;
            $display("%s: no slice or miss event within %0d cycles", name, EVENT_WAIT);
        end else begin
            check_event(name, exp_e, event_out);
            step();
        end
    endtask

    task automatic wait_game_over(input string name);
        int n;
        n = 0;
        while (status.state == ST_PLAYING && n < 8 * TICK_DIV) begin
            step();
            n++;
        end
    endtask

    // Four-phase req/ack for one saber sample
    task automatic send_hand(input string name, input int x, input int y);
        int n;
        if (hand_ack !== 1'b0) begin
            errors++;
            $display("%s: hand_ack already high before the request", name);
        end
        hand     = '{x: coord_t'(x), y: coord_t'(y), z: depth_t'(0)};
        hand_req = 1'b1;
        n = 0;
        step();
        while (hand_ack !== 1'b1 && n < 20) begin
            step();
            n++;
        end
        if (hand_ack !== 1'b1) begin
            errors++;
            $display("%s: hand_ack did not rise within 20 cycles", name);
        end
        step();
        if (hand_ack !== 1'b1) begin
            errors++;
            $display("%s: hand_ack dropped while hand_req was still high", name);
        end
        hand_req = 1'b0;
        n = 0;
        step();
        while (hand_ack !== 1'b0 && n < 4) begin
            step();
            n++;
        end
        if (hand_ack !== 1'b0) begin
            errors++;
            $display("%s: hand_ack stayed high after hand_req dropped", name);
        end
    endtask

    //////////////////////////////////////////////////
    // Directed tests

    task automatic test_reset_start();
        check_status("reset", pack_status(ST_IDLE, 0, HEALTH_MAX, 0, 0), status);
        check_event("reset", pack_event(1'b0, 1'b0, 8'd0), event_out);
        if (hand_ack !== 1'b0) begin
            errors++;
            $display("reset: hand_ack is not low after reset");
        end
        start = 1'b1;
        step();
        start = 1'b0;
        check_status("start", pack_status(ST_PLAYING, 0, HEALTH_MAX, 0, 0), status);
    endtask

    // Early in the game, nothing is close enough to be cut
    task automatic test_handshake();
        send_hand("handshake", 100, 100);
        step();
        send_hand("handshake", 140, 100);
        send_hand("handshake", 140, 160);
    endtask

    // Wind-up far from the block, then a swing onto it in the chart direction
    task automatic slice_block(input string name, input int k);
        chart_entry_t e;
        int fx, fy, wx, wy;
        int gain;
        e  = CHART[k];
        fx = int'(e.x) + int'($urandom_range(2 * OFFSET_MAX)) - OFFSET_MAX;
        fy = int'(e.y) + int'($urandom_range(2 * OFFSET_MAX)) - OFFSET_MAX;
        wx = fx;
        wy = fy;
        case (e.dir)
            DIR_UP:   wy = fy + SWING;
            DIR_DOWN: wy = fy - SWING;
            DIR_LEFT: wx = fx + SWING;
            default:  wx = fx - SWING;
        endcase
        wait_time(name, int'(e.arrive) - 4);
        send_hand(name, wx, wy);
        wait_time(name, int'(e.arrive) - 2);
        send_hand(name, fx, fy);
        wait_event(name, pack_event(1'b1, 1'b0, e.id));
        gain = POINTS_PER_HIT * ((exp_combo + 1 < MULT_CAP) ? exp_combo + 1 : MULT_CAP);
        exp_score += gain;
        if (exp_combo < COMBO_MAX) begin
            exp_combo++;
        end
        wait_time(name, int'(e.arrive));
        check_status(name, pack_status(ST_PLAYING, exp_score, exp_health, exp_combo,
                                       int'(e.arrive)), status);
    endtask

    // Block k must not be a LEFT block
    task automatic test_miss(input int k);
        chart_entry_t e;
        e = CHART[k];
        wait_time("miss", int'(e.arrive) - 2);
        // Swing ends outside the hit radius
        send_hand("miss", int'(e.x) + 80, int'(e.y));
        // Onto the block, but moving left
        send_hand("miss", int'(e.x), int'(e.y));
        wait_event("miss", pack_event(1'b0, 1'b1, e.id));
        exp_combo = 0;
        exp_health--;
        check_status("miss", pack_status(ST_PLAYING, exp_score, exp_health, exp_combo,
                                         int'(e.arrive)), status);
    endtask

    task automatic test_win();
        wait_game_over("win");
        check_status("win", pack_status(ST_WON, exp_score, exp_health, exp_combo,
                                        LAST_TICK), status);
    endtask

    task automatic test_lose();
        reset_dut();
        start = 1'b1;
        step();
        start = 1'b0;
        for (int k = 0; k < HEALTH_MAX; k++) begin
            wait_event("lose", pack_event(1'b0, 1'b1, CHART[k].id));
        end
        wait_game_over("lose");
        check_status("lose", pack_status(ST_LOST, 0, 0, 0,
                                         int'(CHART[HEALTH_MAX-1].arrive)), status);
    endtask

    //////////////////////////////////////////////////
    // Main sequence

    initial begin
        void'($urandom(32'hc756));
        errors = 0;
        hand   = '0;
        reset_dut();
        test_reset_start();
        test_handshake();
        test_miss(0);
        slice_block("slice", 1);
        // Five slices in a row, the last two at the multiplier cap
        for (int k = 2; k < CHART_LEN; k++) begin
            slice_block("combo", k);
        end
        test_win();
        test_lose();
        errors += i_dut.i_hand_port.i_hand_checks.failures;
        errors += i_dut.i_game_state.i_event_checks.failures;
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* src.f */
design/beat_pkg.sv
design/hand_sample_port.sv
design/game_state.sv
design/block_positions.sv
design/slice_detector.sv
design/beat_top.sv
testbench/beat_assertions.sv
testbench/beat_tb.sv
